// ==== Bender.yml ====
package:
  name: control_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpuIsaPkg.sv
      - logic/controlPathPkg.sv
      - logic/controlSequencer.sv
      - logic/conditionUnit.sv
      - logic/datapathDecode.sv
      - logic/busStrobeDecode.sv
      - logic/control.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/control_asserts.sv
      - tb/controlTb.sv

// ==== logic/busStrobeDecode.sv ====
// microcode for pad-level memory and system bus strobes
`timescale 1ns/1ps

module busStrobeDecode
   import cpuIsaPkg::*, controlPathPkg::*;
(
   input  majorState_t State,
   input  subCycle_t   SubCycle,
   input  opcode_t     Opcode,
   output logic        MemEn,
   output logic        nWE,
   output logic        nOE,
   output logic        nME,
   output logic        ENB,
   output logic        ALE
);

   logic isLoad;
   logic isStore;

   assign isLoad  = (Opcode == LDW);
   assign isStore = (Opcode == STW);

   always_comb begin
      MemEn = 1'b0;
      nWE   = 1'b0;
      nOE   = 1'b0;
      nME   = 1'b1;
      ENB   = 1'b0;
      ALE   = 1'b0;
      // each access: address latch, two data cycles with nME low, then capture
      if (State == fetch || (State == execute && isLoad)) begin
         nWE = 1'b1;   // reads never write
         case (SubCycle)
            cycle0: begin
               ALE = (State == fetch);
               nOE = (State == fetch);
            end
            cycle1: begin
               ALE   = (State == execute);
               nOE   = (State == execute);
               nME   = (State == execute);
               MemEn = (State == fetch);
            end
            cycle2: begin
               nME   = 1'b0;
               MemEn = 1'b1;
               ENB   = (State == fetch);
            end
            cycle3: begin
               nME   = (State == fetch);
               MemEn = 1'b1;
               ENB   = (State == execute);
            end
            default: MemEn = 1'b1;   // load data held for the register write
         endcase
      end else if (State == execute && isStore) begin
         nOE = 1'b1;   // the bus is driven by the core throughout
         ALE = (SubCycle == cycle1);
         nWE = (SubCycle inside {cycle1, cycle2});
         nME = !(SubCycle inside {cycle2, cycle3});
      end else if (State == interrupt) begin
         // push of the return address, write strobe in cycle3
         ALE = (SubCycle == cycle1);
         nOE = (SubCycle != cycle0);
         nWE = (SubCycle inside {cycle1, cycle2});
         nME = !(SubCycle inside {cycle2, cycle3});
      end
   end

endmodule

// ==== logic/conditionUnit.sv ====
// status register and branch condition evaluation
`timescale 1ns/1ps
`include "cpu_macros.svh"

module conditionUnit
   import cpuIsaPkg::*;
(
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic [`CPU_FLAGS_W-1:0] Flags,
   input  logic                    StatusRegWe,
   input  branch_t                 BranchCode,
   output logic                    BranchTaken,
   output logic                    CFlag
);

   logic [`CPU_FLAGS_W-1:0] statusReg;
   logic                    signLess;   // N differs from V

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusReg <= '0;
      else if (StatusRegWe)
         statusReg <= Flags;   // flags from the ALU op just executed
   end

   assign CFlag    = statusReg[`FLAGS_C];
   assign signLess = statusReg[`FLAGS_N] ^ statusReg[`FLAGS_V];

   always_comb begin
      case (BranchCode)
         BNE:     BranchTaken = ~statusReg[`FLAGS_Z];
         BE:      BranchTaken = statusReg[`FLAGS_Z];
         BLT:     BranchTaken = signLess;
         BGE:     BranchTaken = ~signLess;
         default: BranchTaken = 1'b1;   // BR, BWL, RET, JMP are unconditional
      endcase
   end

endmodule

// ==== logic/control.sv ====
// top level of the control unit: sequencer, condition unit and two decoders
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control
   import cpuIsaPkg::*, controlPathPkg::*;
(
   input  logic                    Clock,
   input  logic                    nReset,
   input  logic                    nIRQ,
   input  logic [`CPU_INSTR_W-1:0] OpcodeCondIn,
   input  logic [`CPU_FLAGS_W-1:0] Flags,
   output aluFn_t                  AluOp,
   output op1Sel_t                 Op1Sel,
   output op2Sel_t                 Op2Sel,
   output immSel_t                 ImmSel,
   output wdSel_t                  WdSel,
   output rs1Sel_t                 Rs1Sel,
   output lrSel_t                  LrSel,
   output pcSel_t                  PcSel,
   output logic                    AluEn,
   output logic                    AluWe,
   output logic                    LrEn,
   output logic                    LrWe,
   output logic                    PcWe,
   output logic                    PcEn,
   output logic                    IrWe,
   output logic                    RegWe,
   output logic                    MemEn,   // pad direction
   output logic                    nWE,
   output logic                    nOE,
   output logic                    nME,
   output logic                    ENB,
   output logic                    ALE,
   output logic                    CFlag
);

   opcode_t     opcode;
   branch_t     branchCode;
   majorState_t state;
   subCycle_t   subCycle;
   logic        statusRegWe;
   logic        intClear;
   logic        branchTaken;

   assign opcode     = opcode_t'(OpcodeCondIn[`CPU_INSTR_W-1 -: `CPU_OPCODE_W]);
   assign branchCode = branch_t'(OpcodeCondIn[`CPU_BRANCH_W-1:0]);

   controlSequencer seq0 (
      .Clock(Clock), .nReset(nReset), .nIRQ(nIRQ), .Opcode(opcode),
      .IntClear(intClear), .State(state), .SubCycle(subCycle)
   );

   conditionUnit cond0 (
      .Clock(Clock), .nReset(nReset), .Flags(Flags), .StatusRegWe(statusRegWe),
      .BranchCode(branchCode), .BranchTaken(branchTaken), .CFlag(CFlag)
   );

   datapathDecode dp0 (
      .State(state), .SubCycle(subCycle), .Opcode(opcode), .BranchCode(branchCode),
      .BranchTaken(branchTaken), .AluOp(AluOp), .Op1Sel(Op1Sel), .Op2Sel(Op2Sel),
      .ImmSel(ImmSel), .WdSel(WdSel), .Rs1Sel(Rs1Sel), .LrSel(LrSel), .PcSel(PcSel),
      .AluEn(AluEn), .AluWe(AluWe), .LrEn(LrEn), .LrWe(LrWe), .PcWe(PcWe), .PcEn(PcEn),
      .IrWe(IrWe), .RegWe(RegWe), .StatusRegWe(statusRegWe), .IntClear(intClear)
   );

   busStrobeDecode bus0 (
      .State(state), .SubCycle(subCycle), .Opcode(opcode), .MemEn(MemEn),
      .nWE(nWE), .nOE(nOE), .nME(nME), .ENB(ENB), .ALE(ALE)
   );

endmodule

// ==== logic/controlPathPkg.sv ====
// datapath select enums and sequencer state enums
`include "cpu_macros.svh"

package controlPathPkg;

   // operand and write-data muxes
   typedef enum logic {
      Op1Rd1,
      Op1Pc
   } op1Sel_t;

   typedef enum logic {
      Op2Rd2,
      Op2Imm
   } op2Sel_t;

   typedef enum logic {
      WdAlu,
      WdSys           // register write from the system bus
   } wdSel_t;

   typedef enum logic {
      ImmShort,
      ImmLong
   } immSel_t;

   typedef enum logic [1:0] {
      Pc1,            // increment
      PcAluOut,
      PcSysbus,
      PcInt           // interrupt vector
   } pcSel_t;

   typedef enum logic {
      LrSys,
      LrPc
   } lrSel_t;

   typedef enum logic [1:0] {
      Rs1Ra,
      Rs1Rd,
      Rs1Sp           // stack pointer
   } rs1Sel_t;

   typedef enum logic [1:0] {
      fetch,
      execute,
      interrupt
   } majorState_t;

   typedef enum logic [$clog2(`CPU_SUBCYCLES)-1:0] {
      cycle0,
      cycle1,
      cycle2,
      cycle3,
      cycle4
   } subCycle_t;

endpackage

// ==== logic/controlSequencer.sv ====
// major state and sub-cycle FSM with interrupt request synchronizer and latch
`timescale 1ns/1ps

module controlSequencer
   import cpuIsaPkg::*, controlPathPkg::*;
(
   input  logic        Clock,
   input  logic        nReset,
   input  logic        nIRQ,
   input  opcode_t     Opcode,
   input  logic        IntClear,
   output majorState_t State,
   output subCycle_t   SubCycle
);

   logic        irqSync;     // nIRQ retimed and inverted
   logic        intReq;      // pending interrupt, held until the sequence ends
   majorState_t nextState;
   subCycle_t   nextSub;
   subCycle_t   subInc;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         irqSync <= 1'b0;
         intReq  <= 1'b0;
      end else begin
         irqSync <= ~nIRQ;
         if (irqSync)
            intReq <= 1'b1;   // a new request wins over the clear
         else if (IntClear)
            intReq <= 1'b0;
      end
   end

   assign subInc = subCycle_t'(SubCycle + 1'b1);

   always_comb begin
      nextState = State;
      nextSub   = subInc;
      case (State)
         fetch: begin
            if (SubCycle == cycle0 && intReq) begin
               nextState = interrupt;   // only taken between instructions
               nextSub   = cycle0;
            end else if (SubCycle == cycle3) begin
               nextState = execute;
               nextSub   = cycle0;
            end
         end
         execute: begin
            if (SubCycle == cycle0 && !(Opcode inside {LDW, STW})) begin
               nextState = fetch;       // single-cycle instructions
               nextSub   = cycle0;
            end else if (SubCycle == cycle4) begin
               nextState = fetch;
               nextSub   = cycle0;
            end
         end
         interrupt: begin
            if (SubCycle == cycle4) begin
               nextState = fetch;
               nextSub   = cycle0;
            end
         end
         default: begin
            nextState = fetch;          // recover from the unused encoding
            nextSub   = cycle0;
         end
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         State    <= fetch;
         SubCycle <= cycle0;
      end else begin
         State    <= nextState;
         SubCycle <= nextSub;
      end
   end

endmodule

// ==== logic/cpuIsaPkg.sv ====
// instruction-set enums: opcodes, branch codes and ALU functions
`include "cpu_macros.svh"

package cpuIsaPkg;

   typedef enum logic [`CPU_OPCODE_W-1:0] {
      ADD   = 5'd0,   // arithmetic, carry in from flags on the C forms
      ADDI, ADDIB, ADC, ADCI,
      SUB, SUBI, SUBIB, SUC, SUCI,
      CMP, CMPI,      // subtract without register write
      AND, OR, XOR, NOT, NAND, NOR,
      NEG,
      LSL, LSR, ASR,  // shift count from the short immediate
      LUI, LLI,
      LDW, STW,       // the only five-cycle instructions
      BRANCH          // branch code selects the flavour
   } opcode_t;

   typedef enum logic [`CPU_BRANCH_W-1:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      BWL = 3'd5,     // branch with link
      RET = 3'd6,     // pc from the link register
      JMP = 3'd7      // register plus short immediate
   } branch_t;

   typedef enum logic [3:0] {
      FnA,            // pass operand 1
      FnADD,
      FnADC,
      FnSUB,
      FnNEG,
      FnAND,
      FnOR,
      FnXOR,
      FnNOT,
      FnNAND,
      FnNOR,
      FnLSL,
      FnLSR,
      FnASR,
      FnLUI,
      FnLLI
   } aluFn_t;

endpackage

// ==== logic/cpu_macros.svh ====
// field widths, flag bit positions and sub-cycle count of the control unit
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction byte is opcode in the upper bits, branch code in the lower ones
`define CPU_OPCODE_W 5
`define CPU_BRANCH_W 3
`define CPU_INSTR_W  8

// status register
`define CPU_FLAGS_W  4
`define FLAGS_Z      0
`define FLAGS_C      1
`define FLAGS_N      2
`define FLAGS_V      3

`define CPU_SUBCYCLES 5   // longest major state, memory and interrupt sequences

`endif

// ==== logic/datapathDecode.sv ====
// microcode for ALU, register file, PC and link register controls
`timescale 1ns/1ps

module datapathDecode
   import cpuIsaPkg::*, controlPathPkg::*;
(
   input  majorState_t State,
   input  subCycle_t   SubCycle,
   input  opcode_t     Opcode,
   input  branch_t     BranchCode,
   input  logic        BranchTaken,
   output aluFn_t      AluOp,
   output op1Sel_t     Op1Sel,
   output op2Sel_t     Op2Sel,
   output immSel_t     ImmSel,
   output wdSel_t      WdSel,
   output rs1Sel_t     Rs1Sel,
   output lrSel_t      LrSel,
   output pcSel_t      PcSel,
   output logic        AluEn,
   output logic        AluWe,
   output logic        LrEn,
   output logic        LrWe,
   output logic        PcWe,
   output logic        PcEn,
   output logic        IrWe,
   output logic        RegWe,
   output logic        StatusRegWe,
   output logic        IntClear
);

   function automatic aluFn_t aluFnOf(input opcode_t op);
      case (op)
         ADD, ADDI, ADDIB:          return FnADD;
         ADC, ADCI, SUC, SUCI:      return FnADC;   // subtract with carry shares the carry adder
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG:                       return FnNEG;
         AND:                       return FnAND;
         OR:                        return FnOR;
         XOR:                       return FnXOR;
         NOT:                       return FnNOT;
         NAND:                      return FnNAND;
         NOR:                       return FnNOR;
         LSL:                       return FnLSL;
         LSR:                       return FnLSR;
         ASR:                       return FnASR;
         LUI:                       return FnLUI;
         LLI:                       return FnLLI;
         default:                   return FnA;
      endcase
   endfunction

   always_comb begin
      AluOp       = FnA;
      Op1Sel      = Op1Rd1;
      Op2Sel      = Op2Imm;
      ImmSel      = ImmLong;
      WdSel       = WdAlu;
      Rs1Sel      = Rs1Ra;
      LrSel       = LrSys;
      PcSel       = Pc1;
      AluEn       = 1'b0;
      AluWe       = 1'b0;
      LrEn        = 1'b0;
      LrWe        = 1'b0;
      PcWe        = 1'b0;
      PcEn        = 1'b0;
      IrWe        = 1'b0;
      RegWe       = 1'b0;
      StatusRegWe = 1'b0;
      IntClear    = 1'b0;
      case (State)
         fetch: begin
            PcEn = (SubCycle == cycle0);   // pc onto the bus for the address phase
            IrWe = (SubCycle == cycle3);
         end
         execute: begin
            case (SubCycle)
               cycle0: begin
                  AluOp = aluFnOf(Opcode);
                  if (Opcode inside {LUI, LLI}) begin
                     Rs1Sel = Rs1Rd;
                     AluEn  = 1'b1;
                     RegWe  = 1'b1;
                     PcWe   = 1'b1;
                  end else if (Opcode inside {LDW, STW}) begin
                     AluOp  = FnADD;       // effective address into the ALU register
                     ImmSel = ImmShort;
                     AluEn  = 1'b1;
                     AluWe  = 1'b1;
                  end else if (Opcode == BRANCH) begin
                     PcWe = 1'b1;
                     case (BranchCode)
                        RET: begin
                           LrEn  = 1'b1;
                           PcSel = PcSysbus;
                        end
                        JMP: begin
                           AluOp  = FnADD;
                           ImmSel = ImmShort;
                           PcSel  = PcAluOut;
                        end
                        default: begin
                           AluOp  = FnADD;   // pc relative target
                           Op1Sel = Op1Pc;
                           AluEn  = 1'b1;
                           if (BranchTaken) begin
                              PcSel = PcAluOut;
                              LrWe  = (BranchCode == BWL);
                              LrSel = (BranchCode == BWL) ? LrPc : LrSys;
                           end
                        end
                     endcase
                  end else if (AluOp != FnA) begin
                     PcEn        = 1'b1;
                     PcWe        = 1'b1;
                     StatusRegWe = 1'b1;
                     RegWe       = !(Opcode inside {CMP, CMPI});
                     if (Opcode inside {ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR})
                        Op2Sel = Op2Rd2;
                     else if (!(Opcode inside {NOT, NEG}))
                        ImmSel = ImmShort;
                     if (Opcode inside {ADDIB, SUBIB})
                        Rs1Sel = Rs1Rd;
                  end
               end
               cycle1: begin
                  AluOp  = FnADD;   // address stays on the bus for the latch
                  ImmSel = ImmShort;
                  AluEn  = 1'b1;
               end
               cycle2: begin
                  Rs1Sel = Rs1Rd;   // store data passes through on the next edge
                  AluEn  = 1'b1;
                  AluWe  = 1'b1;
               end
               cycle3: AluEn = (Opcode == STW);
               cycle4: begin
                  PcWe  = 1'b1;
                  AluEn = (Opcode == STW);
                  if (Opcode == LDW) begin
                     WdSel = WdSys;
                     RegWe = 1'b1;
                  end
               end
               default: ;
            endcase
         end
         interrupt: begin
            case (SubCycle)
               cycle0: begin
                  Rs1Sel = Rs1Sp;   // stack pointer becomes the push address
                  AluEn  = 1'b1;
                  AluWe  = 1'b1;
               end
               cycle1: begin
                  Rs1Sel = Rs1Sp;
                  AluEn  = 1'b1;
               end
               cycle2, cycle3: PcEn = 1'b1;   // return address on the bus
               cycle4: begin
                  PcEn     = 1'b1;
                  PcWe     = 1'b1;
                  PcSel    = PcInt;
                  IntClear = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

// ==== tb/controlTb.sv ====
// clock, reset, vector table, stimulus loop, checks and watchdog of the control unit testbench
`timescale 1ns/1ps
`include "cpu_macros.svh"

module controlTb
   import cpuIsaPkg::*, controlPathPkg::*;
();

   localparam int ClockPeriod = 40;
   localparam int ResetCycles = 8;
   localparam int NumRows     = 40;
   localparam int WaitLimit   = 20;   // cycles allowed from one IrWe to the next

   typedef struct {
      opcode_t                 op;
      branch_t                 br;
      logic [`CPU_FLAGS_W-1:0] flags;   // Z C N V from bit 0 upwards
      int                      len;     // cycles from IrWe to IrWe
   } vector_t;

   // compare rows carry fixed flags so that the branch after them sees a known condition
   vector_t vectors [NumRows] = '{
      '{ADD,    BR,  4'h0, 5}, '{ADDI,   BR,  4'h0, 5}, '{ADDIB,  BR,  4'h0, 5},
      '{ADC,    BR,  4'h0, 5}, '{ADCI,   BR,  4'h0, 5}, '{SUB,    BR,  4'h0, 5},
      '{SUBI,   BR,  4'h0, 5}, '{SUBIB,  BR,  4'h0, 5}, '{SUC,    BR,  4'h0, 5},
      '{SUCI,   BR,  4'h0, 5}, '{AND,    BR,  4'h0, 5}, '{OR,     BR,  4'h0, 5},
      '{XOR,    BR,  4'h0, 5}, '{NOT,    BR,  4'h0, 5}, '{NAND,   BR,  4'h0, 5},
      '{NOR,    BR,  4'h0, 5}, '{NEG,    BR,  4'h0, 5}, '{LSL,    BR,  4'h0, 5},
      '{LSR,    BR,  4'h0, 5}, '{ASR,    BR,  4'h0, 5}, '{LUI,    BR,  4'h0, 5},
      '{LLI,    BR,  4'h0, 5}, '{LDW,    BR,  4'h0, 9}, '{STW,    BR,  4'h0, 9},
      '{CMP,    BR,  4'h3, 5},   // Z and C set
      '{BRANCH, BE,  4'h0, 5}, '{BRANCH, BNE, 4'h0, 5},
      '{CMPI,   BR,  4'h0, 5},
      '{BRANCH, BNE, 4'h0, 5}, '{BRANCH, BE,  4'h0, 5},
      '{CMP,    BR,  4'h6, 5},   // N without V
      '{BRANCH, BLT, 4'h0, 5}, '{BRANCH, BGE, 4'h0, 5},
      '{CMP,    BR,  4'hC, 5},   // N and V
      '{BRANCH, BLT, 4'h0, 5}, '{BRANCH, BGE, 4'h0, 5},
      '{BRANCH, BR,  4'h0, 5}, '{BRANCH, BWL, 4'h0, 5},
      '{BRANCH, RET, 4'h0, 5}, '{BRANCH, JMP, 4'h0, 5}
   };

   logic                    Clock;
   logic                    nReset;
   logic                    nIRQ;
   logic [`CPU_INSTR_W-1:0] OpcodeCondIn;
   logic [`CPU_FLAGS_W-1:0] Flags;
   aluFn_t                  AluOp;
   op1Sel_t                 Op1Sel;
   op2Sel_t                 Op2Sel;
   immSel_t                 ImmSel;
   wdSel_t                  WdSel;
   rs1Sel_t                 Rs1Sel;
   lrSel_t                  LrSel;
   pcSel_t                  PcSel;
   logic                    AluEn;
   logic                    AluWe;
   logic                    LrEn;
   logic                    LrWe;
   logic                    PcWe;
   logic                    PcEn;
   logic                    IrWe;
   logic                    RegWe;
   logic                    MemEn;
   logic                    nWE;
   logic                    nOE;
   logic                    nME;
   logic                    ENB;
   logic                    ALE;
   logic                    CFlag;

   int                      errors;
   int                      checks;
   integer                  seed;
   bit                      lostSync;     // DUT no longer in step with the table
   logic [`CPU_FLAGS_W-1:0] modelFlags;   // flags the status register should hold

   control dut0 (.*);

   initial Clock = 1'b0;
   always #(ClockPeriod / 2) Clock = ~Clock;

   function automatic bit isAluRow(input opcode_t op);
      return !(op inside {LDW, STW, BRANCH});
   endfunction

   function automatic bit setsFlags(input opcode_t op);
      return isAluRow(op) && !(op inside {LUI, LLI});   // load immediates leave the flags
   endfunction

   // immediate ALU forms, shifts take their count from the short immediate
   function automatic bit shortImmForm(input opcode_t op);
      return op inside {ADDI, ADDIB, ADCI, SUBI, SUBIB, SUCI, CMPI, LSL, LSR, ASR};
   endfunction

   function automatic aluFn_t expectedAluFn(input opcode_t op);
      case (op)
         NEG:     return FnNEG;
         AND:     return FnAND;
         OR:      return FnOR;
         XOR:     return FnXOR;
         NOT:     return FnNOT;
         NAND:    return FnNAND;
         NOR:     return FnNOR;
         LSL:     return FnLSL;
         LSR:     return FnLSR;
         ASR:     return FnASR;
         LUI:     return FnLUI;
         LLI:     return FnLLI;
         default: begin
            if (op inside {ADC, ADCI, SUC, SUCI})
               return FnADC;   // carry-in forms
            if (op inside {SUB, SUBI, SUBIB, CMP, CMPI})
               return FnSUB;
            return FnADD;
         end
      endcase
   endfunction

   function automatic bit branchCond(input branch_t br, input logic [`CPU_FLAGS_W-1:0] f);
      case (br)
         BNE:     return !f[`FLAGS_Z];
         BE:      return f[`FLAGS_Z];
         BLT:     return f[`FLAGS_N] != f[`FLAGS_V];
         BGE:     return f[`FLAGS_N] == f[`FLAGS_V];
         default: return 1'b1;
      endcase
   endfunction

   task automatic checkValue(input int got, input int exp, input string what);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // control strobes that must stay low outside of execute
   task automatic checkQuiet(input string when);
      checkValue(RegWe, 0, {when, " RegWe"});
      checkValue(PcWe, 0, {when, " PcWe"});
      checkValue(IrWe, 0, {when, " IrWe"});
      checkValue(LrWe, 0, {when, " LrWe"});
      checkValue(AluWe, 0, {when, " AluWe"});
   endtask

   task automatic checkIdle(input string when);
      checkQuiet(when);
      checkValue(MemEn, 0, {when, " MemEn"});
      checkValue(ENB, 0, {when, " ENB"});
      checkValue(nME, 1, {when, " nME"});
      checkValue(ALE, 1, {when, " ALE"});   // fetch cycle0 address phase
      checkValue(nWE, 1, {when, " nWE"});
      checkValue(nOE, 1, {when, " nOE"});
      checkValue(PcEn, 1, {when, " PcEn"});
   endtask

   task automatic checkExecute(input vector_t v, input bit taken, input string tag);
      pcSel_t expPc;
      if (isAluRow(v.op)) begin
         checkValue(AluOp, expectedAluFn(v.op), {tag, " AluOp"});
         checkValue(RegWe, !(v.op inside {CMP, CMPI}), {tag, " RegWe"});
         checkValue(PcWe, 1, {tag, " PcWe"});
         checkValue(PcSel, Pc1, {tag, " PcSel"});
         checkValue(LrWe, 0, {tag, " LrWe"});
         checkValue(Op1Sel, Op1Rd1, {tag, " Op1Sel"});
         if (shortImmForm(v.op)) begin
            checkValue(Op2Sel, Op2Imm, {tag, " Op2Sel"});
            checkValue(ImmSel, ImmShort, {tag, " ImmSel"});
         end else if (!(v.op inside {NOT, NEG, LUI, LLI})) begin
            checkValue(Op2Sel, Op2Rd2, {tag, " Op2Sel"});   // two register operands
            checkValue(Rs1Sel, Rs1Ra, {tag, " Rs1Sel"});
         end
      end else if (v.op == BRANCH) begin
         if (v.br == RET)
            expPc = PcSysbus;
         else if (taken)
            expPc = PcAluOut;
         else
            expPc = Pc1;
         checkValue(PcWe, 1, {tag, " PcWe"});
         checkValue(PcSel, expPc, {tag, " PcSel"});
         checkValue(RegWe, 0, {tag, " RegWe"});
         checkValue(LrWe, v.br == BWL && taken, {tag, " LrWe"});
         if (v.br == BWL && taken)
            checkValue(LrSel, LrPc, {tag, " LrSel"});
         if (v.br == RET)
            checkValue(LrEn, 1, {tag, " LrEn"});
         if (v.br == JMP) begin
            checkValue(Op1Sel, Op1Rd1, {tag, " Op1Sel"});   // register plus short immediate
            checkValue(Rs1Sel, Rs1Ra, {tag, " Rs1Sel"});
            checkValue(ImmSel, ImmShort, {tag, " ImmSel"});
         end else if (v.br != RET) begin
            checkValue(Op1Sel, Op1Pc, {tag, " Op1Sel"});
         end
      end else begin
         checkValue(RegWe, 0, {tag, " RegWe"});   // address phase only
         checkValue(PcWe, 0, {tag, " PcWe"});
      end
   endtask

   task automatic checkMemory(input vector_t v, input int sub, input string tag);
      checkValue(nME, !(sub inside {2, 3}), {tag, " nME"});
      checkValue(RegWe && WdSel == WdSys, v.op == LDW && sub == 4, {tag, " RegWe from WdSys"});
      if (sub < 2)
         checkValue(AluEn, 1, {tag, " AluEn"});   // address on the bus up to the latch
      if (v.op == STW)
         checkValue(nOE, 1, {tag, " nOE"});
   endtask

   // drives one row at the IrWe edge and steps until the next IrWe
   task automatic applyRow(input vector_t v);
      int                      count;
      bit                      taken;
      logic [`CPU_FLAGS_W-1:0] drive;
      string                   tag;
      tag   = (v.op == BRANCH) ? v.br.name() : v.op.name();
      drive = v.flags;
      if (isAluRow(v.op) && !(v.op inside {CMP, CMPI}))
         drive = 4'($random(seed));
      taken        = branchCond(v.br, modelFlags);
      OpcodeCondIn = {v.op, v.br};
      Flags        = drive;
      count        = 0;
      do begin
         @(negedge Clock);
         count++;
         if (count == 1)
            checkExecute(v, taken, tag);
         if (v.op inside {LDW, STW} && count <= 5)
            checkMemory(v, count - 1, tag);
      end while (!IrWe && count < WaitLimit);
      if (!IrWe) begin
         errors++;
         lostSync = 1'b1;
         $display("ERROR: no instruction fetch completed within %0d cycles after %s",
                  WaitLimit, tag);
      end else begin
         checkValue(count, v.len, {tag, " cycles between IrWe pulses"});
      end
      if (setsFlags(v.op))
         modelFlags = drive;
      checkValue(CFlag, modelFlags[`FLAGS_C], {tag, " CFlag"});
   endtask

   // nIRQ pulse during a load, then the interrupt entry and a normal fetch
   task automatic interruptDuringLoad();
      int count;
      bit sawVector;
      OpcodeCondIn = {LDW, BR};
      Flags        = '0;
      @(negedge Clock);
      nIRQ = 1'b0;   // execute cycle0
      @(negedge Clock);
      nIRQ      = 1'b1;
      count     = 2;
      sawVector = 1'b0;
      while (!sawVector && count < WaitLimit) begin
         @(negedge Clock);
         count++;
         checkValue(IrWe, 0, "IrWe before the interrupt vector");
         sawVector = PcWe && PcSel == PcInt;
      end
      if (!sawVector) begin
         errors++;
         $display("ERROR: the interrupt sequence never loaded the interrupt vector");
      end else begin
         count = 0;
         while (!IrWe && count < WaitLimit) begin
            @(negedge Clock);
            count++;
         end
         if (!IrWe) begin
            errors++;
            $display("ERROR: no instruction fetch after the interrupt sequence");
         end else begin
            checkValue(count, 4, "cycles from PcInt to IrWe");
         end
      end
   endtask

   initial begin
      seed         = 32'hdbbac925;
      errors       = 0;
      checks       = 0;
      lostSync     = 1'b0;
      modelFlags   = '0;
      nReset       = 1'b0;
      nIRQ         = 1'b1;
      OpcodeCondIn = '0;
      Flags        = '0;
      repeat (ResetCycles) begin
         @(negedge Clock);
         checkIdle("reset");
      end
      nReset = 1'b1;
      for (int c = 1; c <= 3; c++) begin
         @(negedge Clock);
         if (c < 3)
            checkQuiet("first fetch");
      end
      checkValue(IrWe, 1, "first IrWe");   // fetch cycle3
      if (!IrWe)
         lostSync = 1'b1;
      for (int i = 0; i < NumRows && !lostSync; i++)
         applyRow(vectors[i]);
      if (!lostSync)
         interruptDuringLoad();
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, dut0.asserts0.failures);
      if (errors == 0 && dut0.asserts0.failures == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      #((NumRows * 14 + 40) * ClockPeriod);
      $display("ERROR: simulation timed out at %0t", $time);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== tb/control_asserts.sv ====
// concurrent assertions on the control outputs and their bind to the top level
`timescale 1ns/1ps

module controlAsserts
   import controlPathPkg::*;
(
   input logic   Clock,
   input logic   nReset,
   input logic   IrWe,
   input logic   PcWe,
   input logic   nME,
   input logic   ALE,
   input logic   RegWe,
   input logic   MemEn,
   input wdSel_t WdSel
);

   int failures = 0;   // failed assertion count

   irPcExclusive: assert property (@(posedge Clock) disable iff (!nReset) !(IrWe && PcWe))
      else begin
         failures++;
         $error("IrWe and PcWe high in the same cycle");
      end

   dataPhaseNoLatch: assert property (@(posedge Clock) disable iff (!nReset) !nME |-> !ALE)
      else begin
         failures++;
         $error("ALE high while nME is low");
      end

   loadWriteOnBus: assert property (@(posedge Clock) disable iff (!nReset)
      (RegWe && WdSel == WdSys) |-> MemEn)
      else begin
         failures++;
         $error("register write from the system bus without MemEn");
      end

endmodule

bind control controlAsserts asserts0 (
   .Clock(Clock), .nReset(nReset), .IrWe(IrWe), .PcWe(PcWe), .nME(nME),
   .ALE(ALE), .RegWe(RegWe), .MemEn(MemEn), .WdSel(WdSel)
);

// ==== vlog.f ====
+incdir+logic
logic/cpuIsaPkg.sv
logic/controlPathPkg.sv
logic/controlSequencer.sv
logic/conditionUnit.sv
logic/datapathDecode.sv
logic/busStrobeDecode.sv
logic/control.sv
tb/control_asserts.sv
tb/controlTb.sv
